// ==== common/pet_pkg.sv ====
`default_nettype none

package pet_pkg;

    typedef enum logic [1:0] {
        NEED_HEALTH = 2'd0,
        NEED_ENERGY = 2'd1,
        NEED_HUNGER = 2'd2,
        NEED_FUN    = 2'd3
    } need_t;

    typedef enum logic [2:0] {
        CMD_NONE    = 3'd0,
        CMD_SELECT  = 3'd1,
        CMD_RAISE   = 3'd2,
        CMD_TOGGLE  = 3'd3,
        CMD_RESTART = 3'd4
    } cmd_t;

    typedef enum logic {
        MODE_NORMAL = 1'b0,
        MODE_TEST   = 1'b1
    } mode_t;

    typedef logic [3:0] level_t;
    typedef level_t [3:0] levels_t;                  // Indexed by need_t

    localparam level_t LEVEL_MAX      = 4'd10;
    localparam level_t LEVEL_START    = 4'd8;       // After reset or restart
    localparam level_t LEVEL_TEST_LOW = 4'd1;
    localparam level_t LEVEL_HAPPY    = 4'd5;

    // Decay periods in ticks
    localparam int DECAY_TIMER_W = 4;
    localparam logic [DECAY_TIMER_W-1:0] DECAY_HEALTH = 4'd12;
    localparam logic [DECAY_TIMER_W-1:0] DECAY_ENERGY = 4'd10;
    localparam logic [DECAY_TIMER_W-1:0] DECAY_HUNGER = 4'd7;
    localparam logic [DECAY_TIMER_W-1:0] DECAY_FUN    = 4'd5;

    localparam int TICK_DIV_DEFAULT = 5_000_000;    // Ten ticks per second at 50 MHz

    // Active-high segments in gfedcba order
    function automatic logic [6:0] seg_of_level(input level_t level);
        logic [6:0] seg;
        case (level)
            4'd0:    seg = 7'b0111111;
            4'd1:    seg = 7'b0000110;
            4'd2:    seg = 7'b1011011;
            4'd3:    seg = 7'b1001111;
            4'd4:    seg = 7'b1100110;
            4'd5:    seg = 7'b1101101;
            4'd6:    seg = 7'b1111101;
            4'd7:    seg = 7'b0000111;
            4'd8:    seg = 7'b1111111;
            4'd9:    seg = 7'b1101111;
            4'd10:   seg = 7'b1110111;              // Letter A
            default: seg = 7'b0000000;              // Blank
        endcase
        return seg;
    endfunction

endpackage

`default_nettype wire

// ==== common/pet_cmd_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface pet_cmd_if;

    logic           tick;                   // One clk cycle per tick period
    logic [3:0]     decay;                  // Bit i belongs to need i
    pet_pkg::cmd_t  cmd;                    // CMD_NONE outside tick cycles
    pet_pkg::need_t need;                   // Target of raise and toggle
    logic           test_mode;

    modport ctrl (
        output cmd,
        output need,
        output test_mode,
        input  tick
    );

    modport timer (
        output tick,
        output decay,
        input  cmd,
        input  test_mode
    );

    modport bank (
        input tick,
        input decay,
        input cmd,
        input need,
        input test_mode
    );

endinterface

`default_nettype wire

// ==== hdl/pet_tick_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module pet_tick_gen #(
    parameter int TICK_DIV = pet_pkg::TICK_DIV_DEFAULT
) (
    input logic      clk,
    input logic      reset,
    pet_cmd_if.timer cmd_bus
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam int TW    = pet_pkg::DECAY_TIMER_W;

    // Order follows need_t
    localparam logic [TW-1:0] PERIOD [4] = '{
        pet_pkg::DECAY_HEALTH,
        pet_pkg::DECAY_ENERGY,
        pet_pkg::DECAY_HUNGER,
        pet_pkg::DECAY_FUN
    };

    logic [CNT_W-1:0] presc;
    logic             tick;
    logic [3:0]       at_end;
    logic             restart;
    logic             run;

    assign tick    = (presc == CNT_W'(TICK_DIV - 1));
    assign restart = (cmd_bus.cmd == pet_pkg::CMD_RESTART);
    assign run     = tick & ~cmd_bus.test_mode;    // Decay frozen in test mode

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            presc <= '0;
        end else if (tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    for (genvar i = 0; i < 4; i++) begin : g_timer
        logic [TW-1:0] count;                       // Ticks since last decay

        assign at_end[i] = (count == PERIOD[i] - 1'b1);

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                count <= '0;
            end else if (tick) begin
                if (restart) begin
                    count <= '0;                    // Realign with the bank
                end else if (!cmd_bus.test_mode) begin
                    count <= at_end[i] ? '0 : count + 1'b1;
                end
            end
        end
    end

    assign cmd_bus.tick  = tick;
    assign cmd_bus.decay = {4{run}} & at_end;

endmodule

`default_nettype wire

// ==== hdl/pet_ctrl_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module pet_ctrl_fsm (
    input  logic           clk,
    input  logic           reset,
    input  logic           btn_health,
    input  logic           btn_energy,
    input  logic           btn_hunger,
    input  logic           btn_fun,
    input  logic           btn_restart,
    input  logic           btn_test,
    input  logic           lights_on,
    output pet_pkg::need_t need_sel,
    pet_cmd_if.ctrl        cmd_bus
);

    pet_pkg::mode_t mode;
    pet_pkg::mode_t mode_next;
    pet_pkg::need_t sel_next;
    pet_pkg::need_t btn_need;
    logic           btn_need_hit;
    pet_pkg::cmd_t  cmd;

    // Highest need button that counts
    always_comb begin
        btn_need_hit = 1'b1;
        btn_need     = need_sel;
        if (btn_health) begin
            btn_need = pet_pkg::NEED_HEALTH;
        end else if (btn_energy && lights_on) begin     // Pet sleeps in the dark
            btn_need = pet_pkg::NEED_ENERGY;
        end else if (btn_hunger) begin
            btn_need = pet_pkg::NEED_HUNGER;
        end else if (btn_fun) begin
            btn_need = pet_pkg::NEED_FUN;
        end else begin
            btn_need_hit = 1'b0;
        end
    end

    always_comb begin
        cmd       = pet_pkg::CMD_NONE;
        mode_next = mode;
        sel_next  = need_sel;
        if (cmd_bus.tick) begin
            if (btn_restart) begin
                cmd       = pet_pkg::CMD_RESTART;
                mode_next = pet_pkg::MODE_NORMAL;
                sel_next  = pet_pkg::NEED_HEALTH;
            end else if (btn_test) begin
                mode_next = pet_pkg::MODE_TEST;
            end else if (btn_need_hit) begin
                if (btn_need != need_sel) begin
                    cmd      = pet_pkg::CMD_SELECT;
                    sel_next = btn_need;
                end else begin
                    case (mode)
                        pet_pkg::MODE_TEST:   cmd = pet_pkg::CMD_TOGGLE;
                        pet_pkg::MODE_NORMAL: cmd = pet_pkg::CMD_RAISE;
                        default:              cmd = pet_pkg::CMD_NONE;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode     <= pet_pkg::MODE_NORMAL;
            need_sel <= pet_pkg::NEED_HEALTH;
        end else begin
            mode     <= mode_next;
            need_sel <= sel_next;
        end
    end

    assign cmd_bus.cmd       = cmd;
    assign cmd_bus.need      = btn_need;
    assign cmd_bus.test_mode = (mode == pet_pkg::MODE_TEST);

endmodule

`default_nettype wire

// ==== hdl/pet_need_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module pet_need_bank (
    input  logic             clk,
    input  logic             reset,
    input  logic             lights_on,
    pet_cmd_if.bank          cmd_bus,
    output pet_pkg::levels_t levels
);

    pet_pkg::levels_t levels_next;

    function automatic pet_pkg::level_t level_up(input pet_pkg::level_t lvl);
        pet_pkg::level_t res;
        if (lvl >= pet_pkg::LEVEL_MAX) begin
            res = pet_pkg::LEVEL_MAX;
        end else begin
            res = lvl + 1'b1;
        end
        return res;
    endfunction

    function automatic pet_pkg::level_t level_down(input pet_pkg::level_t lvl);
        pet_pkg::level_t res;
        if (lvl == '0) begin
            res = '0;                                   // Floor
        end else begin
            res = lvl - 1'b1;
        end
        return res;
    endfunction

    // Test mode swaps between the two extremes
    function automatic pet_pkg::level_t level_toggle(input pet_pkg::level_t lvl);
        pet_pkg::level_t res;
        if (lvl == pet_pkg::LEVEL_TEST_LOW) begin
            res = pet_pkg::LEVEL_MAX;
        end else begin
            res = pet_pkg::LEVEL_TEST_LOW;
        end
        return res;
    endfunction

    always_comb begin
        levels_next = levels;
        for (int i = 0; i < 4; i++) begin
            if (cmd_bus.decay[i]) begin
                if (i == pet_pkg::NEED_ENERGY && !lights_on) begin
                    levels_next[i] = level_up(levels[i]);   // Resting in the dark
                end else begin
                    levels_next[i] = level_down(levels[i]);
                end
            end
            // Commands override decay on the same need
            case (cmd_bus.cmd)
                pet_pkg::CMD_RESTART: begin
                    levels_next[i] = pet_pkg::LEVEL_START;
                end
                pet_pkg::CMD_RAISE: begin
                    if (cmd_bus.need == pet_pkg::need_t'(i)) begin
                        levels_next[i] = level_up(levels[i]);
                    end
                end
                pet_pkg::CMD_TOGGLE: begin
                    if (cmd_bus.need == pet_pkg::need_t'(i)) begin
                        levels_next[i] = level_toggle(levels[i]);
                    end
                end
                default: ;                              // Select leaves levels alone
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            levels <= {4{pet_pkg::LEVEL_START}};
        end else if (cmd_bus.tick) begin
            levels <= levels_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pet_display.sv ====
`timescale 1ns/100ps
`default_nettype none

module pet_display (
    input  logic             clk,
    input  logic             reset,
    input  pet_pkg::levels_t levels,
    input  pet_pkg::need_t   need_sel,
    output logic             happy,
    output logic [6:0]       seg
);

    pet_pkg::level_t level;

    assign level = levels[need_sel];                    // Level of the selected need

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            happy <= (pet_pkg::LEVEL_START >= pet_pkg::LEVEL_HAPPY);
            seg   <= pet_pkg::seg_of_level(pet_pkg::LEVEL_START);
        end else begin
            happy <= (level >= pet_pkg::LEVEL_HAPPY);
            seg   <= pet_pkg::seg_of_level(level);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pet_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pet_top #(
    parameter int TICK_DIV = pet_pkg::TICK_DIV_DEFAULT
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       btn_health,
    input  logic       btn_energy,
    input  logic       btn_hunger,
    input  logic       btn_fun,
    input  logic       btn_restart,
    input  logic       btn_test,
    input  logic       lights_on,
    output logic [1:0] need_sel,
    output logic       happy,
    output logic [6:0] seg,
    output logic       test_active
);

    pet_pkg::need_t   sel;
    pet_pkg::levels_t levels;

    pet_cmd_if cmd_bus ();

    pet_tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) i_pet_tick_gen (
        .clk     (clk),
        .reset   (reset),
        .cmd_bus (cmd_bus.timer)
    );

    pet_ctrl_fsm i_pet_ctrl_fsm (
        .clk         (clk),
        .reset       (reset),
        .btn_health  (btn_health),
        .btn_energy  (btn_energy),
        .btn_hunger  (btn_hunger),
        .btn_fun     (btn_fun),
        .btn_restart (btn_restart),
        .btn_test    (btn_test),
        .lights_on   (lights_on),
        .need_sel    (sel),
        .cmd_bus     (cmd_bus.ctrl)
    );

    pet_need_bank i_pet_need_bank (
        .clk       (clk),
        .reset     (reset),
        .lights_on (lights_on),
        .cmd_bus   (cmd_bus.bank),
        .levels    (levels)
    );

    pet_display i_pet_display (
        .clk      (clk),
        .reset    (reset),
        .levels   (levels),
        .need_sel (sel),
        .happy    (happy),
        .seg      (seg)
    );

    assign need_sel    = sel;
    assign test_active = cmd_bus.test_mode;            // Changes at the tick edge

endmodule

`default_nettype wire

// ==== verif/pet_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module pet_checker (
    input  logic       compare,
    input  int         step,
    input  logic [1:0] need_sel,
    input  logic       happy,
    input  logic [6:0] seg,
    input  logic       test_active,
    input  logic [1:0] exp_need_sel,
    input  logic       exp_happy,
    input  logic [6:0] exp_seg,
    input  logic       exp_test_active,
    output int         check_count,
    output int         step_fail_count,
    output int         error_count
);

    int step_errors;                                    // Mismatches in the current step

    task automatic check_field(input string name, input logic [6:0] got,
                               input logic [6:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: step %0d %s is %0h, expected %0h",
                     $time, step, name, got, exp);
            error_count++;
            step_errors++;
        end
    endtask

    initial begin
        check_count     = 0;
        step_fail_count = 0;
        error_count     = 0;
        step_errors     = 0;
    end

    // Outputs are stable half way through a tick period
    always @(posedge compare) begin
        step_errors = 0;
        check_field("need_sel", 7'(need_sel), 7'(exp_need_sel));
        check_field("happy", 7'(happy), 7'(exp_happy));
        check_field("seg", seg, exp_seg);
        check_field("test_active", 7'(test_active), 7'(exp_test_active));
        check_count++;
        if (step_errors != 0) begin
            step_fail_count++;
        end
    end

endmodule

`default_nettype wire

// ==== verif/pet_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module pet_tb;

    localparam int TICK_DIV   = 8;
    localparam int CLK_PERIOD = 4;                      // ns
    localparam int RESET_CYC  = 5;
    localparam int DRIVE_DLY  = 1;                      // ns after the rising edge
    localparam int MAX_STEPS  = 256;

    logic       clk;
    logic       reset;
    logic       btn_health;
    logic       btn_energy;
    logic       btn_hunger;
    logic       btn_fun;
    logic       btn_restart;
    logic       btn_test;
    logic       lights_on;
    logic [1:0] need_sel;
    logic       happy;
    logic [6:0] seg;
    logic       test_active;

    logic       compare;                                // Strobe to the checker
    int         step_num;
    logic [1:0] exp_need_sel;
    logic       exp_happy;
    logic [6:0] exp_seg;
    logic       exp_test_active;
    int         check_count;
    int         step_fail_count;
    int         error_count;

    // Expected values packed as {need_sel, happy, seg, test_active}
    logic [5:0]  stim_btn    [MAX_STEPS];
    logic        stim_lights [MAX_STEPS];
    int          stim_idle   [MAX_STEPS];
    logic [10:0] stim_exp    [MAX_STEPS];
    int          n_steps;
    int          max_idle;
    int          load_errors;
    logic        stim_ready;
    longint      timeout_ns;

    pet_top #(
        .TICK_DIV (TICK_DIV)
    ) i_pet_top (
        .clk         (clk),
        .reset       (reset),
        .btn_health  (btn_health),
        .btn_energy  (btn_energy),
        .btn_hunger  (btn_hunger),
        .btn_fun     (btn_fun),
        .btn_restart (btn_restart),
        .btn_test    (btn_test),
        .lights_on   (lights_on),
        .need_sel    (need_sel),
        .happy       (happy),
        .seg         (seg),
        .test_active (test_active)
    );

    pet_checker i_pet_checker (
        .compare         (compare),
        .step            (step_num),
        .need_sel        (need_sel),
        .happy           (happy),
        .seg             (seg),
        .test_active     (test_active),
        .exp_need_sel    (exp_need_sel),
        .exp_happy       (exp_happy),
        .exp_seg         (exp_seg),
        .exp_test_active (exp_test_active),
        .check_count     (check_count),
        .step_fail_count (step_fail_count),
        .error_count     (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_stim();
        int               fd;
        int               n_fields;
        int               line_no;
        int               idle;
        int               need;
        logic [8*160-1:0] line;
        logic [5:0]       btn;
        logic             lights;
        logic             hap;
        logic [6:0]       sg;
        logic             tst;
        fd = $fopen("verif/pet_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file verif/pet_stim.txt");
            load_errors++;
        end else begin
            line_no = 0;
            line    = '0;
            while ($fgets(line, fd) != 0) begin
                line_no++;
                n_fields = $sscanf(line, "%b %b %d %d %b %h %b",
                                   btn, lights, idle, need, hap, sg, tst);
                if (n_fields == 7 && idle >= 1 && need >= 0 && need <= 3
                        && n_steps < MAX_STEPS) begin
                    stim_btn[n_steps]    = btn;
                    stim_lights[n_steps] = lights;
                    stim_idle[n_steps]   = idle;
                    stim_exp[n_steps]    = {need[1:0], hap, sg, tst};
                    if (idle > max_idle) begin
                        max_idle = idle;
                    end
                    n_steps++;
                end else if (n_fields > 0) begin           // Comment and blank lines give 0
                    $display("Stimulus line %0d is malformed or out of range", line_no);
                    load_errors++;
                end
                line = '0;
            end
            $fclose(fd);
        end
    endtask

    // From just after one tick period start to just after a later one
    task automatic wait_ticks(input int n);
        repeat (n * TICK_DIV) @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic apply_step(input int idx);
        lights_on = stim_lights[idx];
        {btn_restart, btn_test, btn_health, btn_energy, btn_hunger, btn_fun} = stim_btn[idx];
        wait_ticks(1);
        {btn_restart, btn_test, btn_health, btn_energy, btn_hunger, btn_fun} = '0;
        {exp_need_sel, exp_happy, exp_seg, exp_test_active} = stim_exp[idx];
        step_num = idx + 1;
        wait_ticks(stim_idle[idx] - 1);
        repeat (TICK_DIV / 2) @(posedge clk);          // Middle of the last idle period
        #DRIVE_DLY compare = 1'b1;
        #DRIVE_DLY compare = 1'b0;
        repeat (TICK_DIV - TICK_DIV / 2) @(posedge clk);
        #DRIVE_DLY;
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        reset     = 1'b1;
        lights_on = 1'b1;
        compare   = 1'b0;
        step_num  = 0;
        {btn_restart, btn_test, btn_health, btn_energy, btn_hunger, btn_fun} = '0;
        {exp_need_sel, exp_happy, exp_seg, exp_test_active} = '0;
        n_steps     = 0;
        max_idle    = 0;
        load_errors = 0;
        stim_ready  = 1'b0;
        load_stim();
        timeout_ns = longint'(n_steps) * (max_idle + 2) * TICK_DIV * CLK_PERIOD + 1000;
        stim_ready = (load_errors == 0) && (n_steps > 0);
        repeat (RESET_CYC) @(posedge clk);
        #DRIVE_DLY reset = 1'b0;                        // Tick period starts here
        if (stim_ready) begin
            for (int i = 0; i < n_steps; i++) begin
                apply_step(i);
            end
        end
        $display("Summary: %0d of %0d steps checked, %0d failed, %0d errors, %0d load errors",
                 check_count, n_steps, step_fail_count, error_count, load_errors);
        if (stim_ready && error_count == 0 && check_count == n_steps) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        wait (stim_ready);
        #(timeout_ns);
        $display("Watchdog timeout: the test steps did not finish within %0d ns", timeout_ns);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/pet_stim.txt ====
# buttons(restart test health energy hunger fun) lights idle_ticks | need_sel happy seg(hex gfedcba) test_active
# Buttons act on the first tick; the compare falls half way through the last idle tick (idle >= 1)
000000 1  1  0 1 7f 0   # Reset state
000100 1  1  1 1 7f 0   # Select energy
000100 1  1  1 1 6f 0   # Raise energy to 9
000100 1  1  1 1 77 0   # Raise to 10
000100 1  1  1 1 77 0   # Stays at 10
000001 1  1  3 1 7d 0   # Select fun at 6
000000 1  3  3 1 6d 0   # Fun decays to 5
000000 1  4  3 0 66 0   # Fun at 4 and not happy
000000 1 26  3 0 3f 0   # Fun floors at 0
000100 0  1  3 0 3f 0   # Energy button ignored in the dark
000100 1  1  1 1 07 0   # Select energy at 7
000000 0 18  1 1 6f 0   # Energy recovers to 9
000000 0 19  1 1 77 0   # Recovery stops at 10
000000 1 10  1 1 6f 0   # Lights on and energy decays
100000 1  1  0 1 7f 0   # Restart
010000 1  1  0 1 7f 1   # Enter test mode
001000 1  1  0 0 06 1   # Toggle health 8 to 1
001000 1  1  0 1 77 1   # Toggle to 10
001000 1  1  0 0 06 1   # Toggle back to 1
000000 1 20  0 0 06 1   # No decay in test mode
000001 1  1  3 1 7f 1   # Select fun still at 8
000001 1  1  3 0 06 1   # Toggle fun 8 to 1
010011 1  1  3 0 06 1   # Test beats need buttons
001010 1  1  0 0 06 1   # Health beats hunger
111111 1  1  0 1 7f 0   # Restart beats everything
000111 1  1  1 1 7f 0   # Energy beats hunger and fun
000110 0  1  2 1 7f 0   # Dark energy skipped so hunger wins
000011 1  1  2 1 6f 0   # Hunger raise beats fun
000000 1  5  2 1 7f 0   # Hunger decayed back to 8
000010 1  1  2 1 6f 0   # Raise wins over decay in the same tick

// ==== project.f ====
common/pet_pkg.sv
common/pet_cmd_if.sv
hdl/pet_tick_gen.sv
hdl/pet_ctrl_fsm.sv
hdl/pet_need_bank.sv
hdl/pet_display.sv
hdl/pet_top.sv
verif/pet_checker.sv
verif/pet_tb.sv
